// File: hw/z8IsaPkg.sv
package z8IsaPkg;

    // values match the high nibble of column 2 where the op exists there
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_ADC = 4'h1,
        ALU_SUB = 4'h2,
        ALU_SBC = 4'h3,
        ALU_OR  = 4'h4,
        ALU_AND = 4'h5,
        ALU_TCM = 4'h6,
        ALU_TM  = 4'h7,
        ALU_CP  = 4'hA,
        ALU_XOR = 4'hB,
        ALU_LD  = 4'hC,
        ALU_INC = 4'hD,
        ALU_DEC = 4'hE
    } aluOpT;

    typedef enum logic [3:0] {
        ST_FETCH,
        ST_READ_INSTR,
        ST_WAIT2,
        ST_READ2,
        ST_WAIT3,
        ST_READ3,
        ST_DECODE,
        ST_ALU2_OP,
        ST_ALU1_OP,
        ST_DJNZ1,
        ST_DJNZ2,
        ST_PORT_WAIT
    } seqStateT;

    // flag bit positions
    localparam int FLAG_C = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_S = 5;
    localparam int FLAG_V = 4;

    localparam logic [7:0] REG_FLAGS = 8'hFC;
    localparam logic [7:0] REG_PORT2 = 8'h02;

    // carry flag operations from scf, rcf and ccf
    localparam logic [1:0] CARRY_NONE  = 2'd0;
    localparam logic [1:0] CARRY_SET   = 2'd1;
    localparam logic [1:0] CARRY_RESET = 2'd2;
    localparam logic [1:0] CARRY_CPL   = 2'd3;

endpackage

// File: hw/z8BusPkg.sv
package z8BusPkg;

    import z8IsaPkg::*;

    typedef struct packed {
        logic        strobe;
        logic [15:0] addr;
    } memReqT;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
    } loadReqT;

    typedef struct packed {
        logic       en;
        logic [7:0] addr;
        logic [7:0] data;
    } regWriteT;

    typedef struct packed {
        aluOpT      op;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] flags;
    } aluReqT;

    // writeResult is low for compare and test ops
    typedef struct packed {
        logic [7:0] result;
        logic [7:0] flags;
        logic       writeResult;
    } aluRespT;

endpackage

// File: hw/codeMemory.sv
`timescale 1ns/1ps

module codeMemory
    import z8BusPkg::*;
#(
    parameter int codeAddrWidth = 13
) (
    input  logic       clk,
    input  logic       loadValid,
    output logic       loadReady,
    input  loadReqT    load,
    input  memReqT     memReq,
    output logic [7:0] rdData
);
    localparam int unsigned depth = 1 << codeAddrWidth;

    logic [7:0] mem [0:depth-1];
    logic       inRange;

    // the core has priority, loads fill the gaps between fetches
    assign loadReady = !memReq.strobe;

    assign inRange = 32'(load.addr) < depth;

    always_ff @(posedge clk) begin
        if (memReq.strobe) begin
            rdData <= mem[memReq.addr[codeAddrWidth-1:0]];
        end else if (loadValid && inRange) begin
            mem[load.addr[codeAddrWidth-1:0]] <= load.data;
        end
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu
    import z8IsaPkg::*;
    import z8BusPkg::*;
(
    input  aluReqT  req,
    output aluRespT resp
);
    logic [8:0] sum;
    logic [8:0] diff;
    logic       carryIn;
    logic [7:0] result;
    logic       carry;
    logic       overflow;
    logic       keepFlags;
    logic       writeResult;

    assign carryIn = (req.op == ALU_ADC || req.op == ALU_SBC) ? req.flags[FLAG_C] : 1'b0;

    // bit 8 is carry out for sum, borrow for diff
    assign sum  = {1'b0, req.a} + {1'b0, req.b} + 9'(carryIn);
    assign diff = {1'b0, req.a} - {1'b0, req.b} - 9'(carryIn);

    always_comb begin
        result      = req.a;
        carry       = req.flags[FLAG_C];
        overflow    = req.flags[FLAG_V];
        keepFlags   = 1'b0;
        writeResult = 1'b1;
        case (req.op)
            ALU_LD: begin
                keepFlags = 1'b1;
            end
            ALU_INC: begin
                result   = req.a + 8'd1;
                overflow = req.a == 8'h7F;
            end
            ALU_DEC: begin
                result   = req.a - 8'd1;
                overflow = req.a == 8'h80;
            end
            ALU_ADD, ALU_ADC: begin
                result   = sum[7:0];
                carry    = sum[8];
                overflow = (req.a[7] == req.b[7]) && (sum[7] != req.a[7]);
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                result      = diff[7:0];
                carry       = diff[8];
                overflow    = (req.a[7] != req.b[7]) && (diff[7] != req.a[7]);
                writeResult = req.op != ALU_CP;
            end
            ALU_OR: begin
                result   = req.a | req.b;
                overflow = 1'b0;
            end
            ALU_AND: begin
                result   = req.a & req.b;
                overflow = 1'b0;
            end
            ALU_XOR: begin
                result   = req.a ^ req.b;
                overflow = 1'b0;
            end
            ALU_TCM: begin
                result      = ~req.a & req.b;
                overflow    = 1'b0;
                writeResult = 1'b0;
            end
            ALU_TM: begin
                result      = req.a & req.b;
                overflow    = 1'b0;
                writeResult = 1'b0;
            end
            default: begin
                keepFlags = 1'b1;
            end
        endcase
    end

    always_comb begin
        resp.result      = result;
        resp.writeResult = writeResult;
        resp.flags       = req.flags;
        if (!keepFlags) begin
            resp.flags[FLAG_C] = carry;
            resp.flags[FLAG_Z] = result == 8'h00;
            resp.flags[FLAG_S] = result[7];
            resp.flags[FLAG_V] = overflow;
        end
    end

endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile
    import z8IsaPkg::*;
    import z8BusPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic [7:0] rdAddrA,
    input  logic [7:0] rdAddrB,
    output logic [7:0] rdDataA,
    output logic [7:0] rdDataB,
    input  regWriteT   wr,
    input  logic       flagWrite,
    input  logic [7:0] newFlags,
    output logic [7:0] flags,
    input  logic [1:0] carryOp,
    output logic       portValid,
    input  logic       portReady,
    output logic [7:0] portData
);
    logic [7:0] regs [0:127];
    logic [7:0] flagsReg;
    logic       portLoad;

    // only the low half and the flags register exist
    assign rdDataA = !rdAddrA[7] ? regs[rdAddrA[6:0]]
                   : (rdAddrA == REG_FLAGS) ? flagsReg : 8'h00;
    assign rdDataB = !rdAddrB[7] ? regs[rdAddrB[6:0]]
                   : (rdAddrB == REG_FLAGS) ? flagsReg : 8'h00;

    assign flags    = flagsReg;
    assign portLoad = wr.en && wr.addr == REG_PORT2;

    always_ff @(posedge clk) begin
        if (wr.en && !wr.addr[7]) begin
            regs[wr.addr[6:0]] <= wr.data;
        end
    end

    // alu flags win over a direct write to the flags register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagsReg <= 8'h00;
        end else if (flagWrite) begin
            flagsReg <= newFlags;
        end else if (wr.en && wr.addr == REG_FLAGS) begin
            flagsReg <= wr.data;
        end else begin
            case (carryOp)
                CARRY_SET:   flagsReg[FLAG_C] <= 1'b1;
                CARRY_RESET: flagsReg[FLAG_C] <= 1'b0;
                CARRY_CPL:   flagsReg[FLAG_C] <= ~flagsReg[FLAG_C];
                default:     flagsReg[FLAG_C] <= flagsReg[FLAG_C];
            endcase
        end
    end

    // port 2 stream, held until the sink takes it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            portValid <= 1'b0;
        end else if (portLoad) begin
            portValid <= 1'b1;
        end else if (portReady) begin
            portValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (portLoad) begin
            portData <= wr.data;
        end
    end

endmodule

// File: hw/instrSequencer.sv
`timescale 1ns/1ps

module instrSequencer
    import z8IsaPkg::*;
    import z8BusPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       run,
    output memReqT     memReq,
    input  logic [7:0] rdData,
    output logic [7:0] rdAddrA,
    output logic [7:0] rdAddrB,
    input  logic [7:0] rdDataA,
    input  logic [7:0] rdDataB,
    output regWriteT   wr,
    output logic       flagWrite,
    output logic [1:0] carryOp,
    input  logic [7:0] flags,
    output aluReqT     aluReq,
    input  aluRespT    aluResp,
    input  logic       portValid,
    input  logic       portReady
);
    seqStateT    state;
    seqStateT    nextState;
    logic [15:0] pc;
    logic [15:0] nextPc;
    logic [15:0] relTarget;
    logic [7:0]  instr;
    logic [7:0]  second;
    logic [7:0]  third;
    logic [3:0]  instrH;
    logic [3:0]  instrL;
    logic        size1;
    logic        size3;
    logic        isAlu2;
    logic        condTrue;
    logic        takeBranch;
    logic        portWrite;

    assign instrH = instr[7:4];
    assign instrL = instr[3:0];

    // length from the low nibble: columns E/F one byte, 4-7 and D three
    assign size1  = instrL[3:1] == 3'b111;
    assign size3  = instrL[3:2] == 2'b01 || instrL == 4'hD;
    assign isAlu2 = instrH inside {[4'h0:4'h7], 4'hA, 4'hB};

    // pc already points past the instruction here
    assign relTarget = pc + {{8{second[7]}}, second};
    assign portWrite = wr.en && wr.addr == REG_PORT2;

    always_comb begin
        case (instrH[2:0])
            3'd0: condTrue = 1'b0;
            3'd1: condTrue = flags[FLAG_S] ^ flags[FLAG_V];
            3'd2: condTrue = (flags[FLAG_S] ^ flags[FLAG_V]) | flags[FLAG_Z];
            3'd3: condTrue = flags[FLAG_C] | flags[FLAG_Z];
            3'd4: condTrue = flags[FLAG_V];
            3'd5: condTrue = flags[FLAG_S];
            3'd6: condTrue = flags[FLAG_Z];
            default: condTrue = flags[FLAG_C];
        endcase
    end
    assign takeBranch = condTrue ^ instrH[3];

    // every fetch strobe pauses while run is low
    assign memReq.strobe = run && (state == ST_FETCH
                                   || (state == ST_WAIT2 && !size1)
                                   || state == ST_WAIT3);
    assign memReq.addr   = pc;

    // rN is register N
    assign rdAddrA = {4'h0, (instrL == 4'h2) ? second[7:4] : instrH};
    assign rdAddrB = {4'h0, second[3:0]};

    always_comb begin
        aluReq.op    = ALU_LD;
        aluReq.a     = second;
        aluReq.b     = rdDataB;
        aluReq.flags = flags;
        wr.en        = 1'b0;
        wr.addr      = rdAddrA;
        wr.data      = aluResp.result;
        flagWrite    = 1'b0;
        carryOp      = CARRY_NONE;
        case (state)
            ST_DECODE: begin
                // ld r, #imm passes the immediate through the alu
                wr.en = instrL == 4'hC;
                if (instrL == 4'hF) begin
                    case (instrH)
                        4'hC: carryOp = CARRY_RESET;
                        4'hD: carryOp = CARRY_SET;
                        4'hE: carryOp = CARRY_CPL;
                        default: carryOp = CARRY_NONE;
                    endcase
                end
            end
            ST_ALU2_OP: begin
                aluReq.op = aluOpT'(instrH);
                aluReq.a  = rdDataA;
                wr.en     = aluResp.writeResult;
                flagWrite = 1'b1;
            end
            ST_ALU1_OP: begin
                aluReq.op = ALU_INC;
                aluReq.a  = rdDataA;
                wr.en     = 1'b1;
                flagWrite = 1'b1;
            end
            ST_DJNZ1: begin
                // djnz leaves the flags alone
                aluReq.op = ALU_DEC;
                aluReq.a  = rdDataA;
                wr.en     = 1'b1;
            end
            default: begin
                wr.en = 1'b0;
            end
        endcase
    end

    always_comb begin
        nextState = state;
        nextPc    = pc;
        case (state)
            ST_FETCH: begin
                if (run) begin
                    nextState = ST_READ_INSTR;
                end
            end
            ST_READ_INSTR: begin
                nextState = ST_WAIT2;
                nextPc    = pc + 16'd1;
            end
            ST_WAIT2: begin
                if (size1) begin
                    nextState = ST_DECODE;
                end else if (run) begin
                    nextState = ST_READ2;
                end
            end
            ST_READ2: begin
                nextState = size3 ? ST_WAIT3 : ST_DECODE;
                nextPc    = pc + 16'd1;
            end
            ST_WAIT3: begin
                if (run) begin
                    nextState = ST_READ3;
                end
            end
            ST_READ3: begin
                nextState = ST_DECODE;
                nextPc    = pc + 16'd1;
            end
            ST_DECODE: begin
                nextState = ST_FETCH;
                case (instrL)
                    4'h2: nextState = isAlu2 ? ST_ALU2_OP : ST_FETCH;
                    4'hA: nextState = ST_DJNZ1;
                    4'hB: nextPc = takeBranch ? relTarget : pc;
                    4'hC: nextState = portWrite ? ST_PORT_WAIT : ST_FETCH;
                    4'hD: nextPc = takeBranch ? {second, third} : pc;
                    4'hE: nextState = ST_ALU1_OP;
                    default: nextState = ST_FETCH;
                endcase
            end
            ST_ALU2_OP, ST_ALU1_OP: begin
                nextState = portWrite ? ST_PORT_WAIT : ST_FETCH;
            end
            ST_DJNZ1: nextState = ST_DJNZ2;
            ST_DJNZ2: begin
                // register already holds the decremented count
                if (rdDataA != 8'h00) begin
                    nextPc = relTarget;
                end
                nextState = ST_FETCH;
                // port byte from djnz r2 is already up here
                if (rdAddrA == REG_PORT2 && !(portValid && portReady)) begin
                    nextState = ST_PORT_WAIT;
                end
            end
            ST_PORT_WAIT: begin
                if (portValid && portReady) begin
                    nextState = ST_FETCH;
                end
            end
            default: nextState = ST_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= ST_FETCH;
            pc    <= 16'h000C;
        end else begin
            state <= nextState;
            pc    <= nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_READ_INSTR) begin
            instr <= rdData;
        end
        if (state == ST_READ2) begin
            second <= rdData;
        end
        if (state == ST_READ3) begin
            third <= rdData;
        end
    end

endmodule

// File: hw/z8Soc.sv
`timescale 1ns/1ps

module z8Soc
    import z8BusPkg::*;
#(
    parameter int codeAddrWidth = 13
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       run,
    input  logic       loadValid,
    output logic       loadReady,
    input  loadReqT    load,
    output logic       portValid,
    input  logic       portReady,
    output logic [7:0] portData
);
    memReqT     memReq;
    logic [7:0] rdData;
    logic [7:0] rdAddrA;
    logic [7:0] rdAddrB;
    logic [7:0] rdDataA;
    logic [7:0] rdDataB;
    regWriteT   wr;
    logic       flagWrite;
    logic [1:0] carryOp;
    logic [7:0] flags;
    aluReqT     aluReq;
    aluRespT    aluResp;

    codeMemory #(
        .codeAddrWidth(codeAddrWidth)
    ) u_codeMemory (
        .clk      (clk),
        .loadValid(loadValid),
        .loadReady(loadReady),
        .load     (load),
        .memReq   (memReq),
        .rdData   (rdData)
    );

    instrSequencer u_instrSequencer (
        .clk      (clk),
        .rstN     (rstN),
        .run      (run),
        .memReq   (memReq),
        .rdData   (rdData),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .wr       (wr),
        .flagWrite(flagWrite),
        .carryOp  (carryOp),
        .flags    (flags),
        .aluReq   (aluReq),
        .aluResp  (aluResp),
        .portValid(portValid),
        .portReady(portReady)
    );

    alu u_alu (
        .req (aluReq),
        .resp(aluResp)
    );

    registerFile u_registerFile (
        .clk      (clk),
        .rstN     (rstN),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .wr       (wr),
        .flagWrite(flagWrite),
        .newFlags (aluResp.flags),
        .flags    (flags),
        .carryOp  (carryOp),
        .portValid(portValid),
        .portReady(portReady),
        .portData (portData)
    );

endmodule

// File: bench/z8Soc_props.sv
`timescale 1ns/1ps

module z8SocProps
    import z8BusPkg::*;
(
    input logic       clk,
    input logic       rstN,
    input logic       run,
    input memReqT     memReq,
    input regWriteT   wr,
    input logic       flagWrite,
    input logic       portValid,
    input logic       portReady,
    input logic [7:0] portData
);

    // a pending port byte stays put until the sink takes it
    portHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        portValid && !portReady |=> portValid && $stable(portData)
    ) else $error("port 2 byte dropped or changed before portReady");

    quietInReset: assert property (
        @(posedge clk)
        !rstN |-> !portValid && !memReq.strobe && !wr.en && !flagWrite
    ) else $error("port, fetch or write activity during reset");

    noFetchWhenStopped: assert property (
        @(posedge clk) disable iff (!rstN)
        !run |-> !memReq.strobe
    ) else $error("fetch strobe while run is low");

endmodule

bind z8Soc z8SocProps u_z8SocProps (
    .clk      (clk),
    .rstN     (rstN),
    .run      (run),
    .memReq   (memReq),
    .wr       (wr),
    .flagWrite(flagWrite),
    .portValid(portValid),
    .portReady(portReady),
    .portData (portData)
);

// File: bench/z8SocTb.sv
`timescale 1ns/1ps

module z8SocTb
    import z8BusPkg::*;
();
    logic       clk = 1'b0;
    logic       rstN;
    logic       run;
    logic       loadValid;
    logic       loadReady;
    loadReqT    load;
    logic       portValid;
    logic       portReady;
    logic [7:0] portData;

    logic [15:0] loadAddrQ[$];
    logic [7:0]  loadDataQ[$];
    logic [7:0]  expectQ[$];
    int          expectCount = 0;
    int          received = 0;
    int          budget = 0;
    integer      seed = 79888;
    logic        running = 1'b0;

    z8Soc #(
        .codeAddrWidth(13)
    ) u_z8Soc (
        .clk      (clk),
        .rstN     (rstN),
        .run      (run),
        .loadValid(loadValid),
        .loadReady(loadReady),
        .load     (load),
        .portValid(portValid),
        .portReady(portReady),
        .portData (portData)
    );

    always #4 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input logic [7:0] actual, input logic [7:0] expected,
                              input int index);
        if (actual !== expected) begin
            abortRun($sformatf("Fail at %0t ns: port 2 byte %0d is %02h, expected %02h",
                               $time, index, actual, expected));
        end
    endtask

    // line kinds: L addr byte, E byte, B cycles, # comment
    task automatic readStimulus();
        integer           fd;
        integer           got;
        logic [7:0]       tag;
        logic [15:0]      addr;
        logic [7:0]       value;
        logic [8*128-1:0] skipped;
        fd = $fopen("bench/z8Stimulus.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open bench/z8Stimulus.txt");
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "#": got = $fgets(skipped, fd);
                    "L": begin
                        got = $fscanf(fd, "%h %h", addr, value);
                        loadAddrQ.push_back(addr);
                        loadDataQ.push_back(value);
                    end
                    "E": begin
                        got = $fscanf(fd, "%h", value);
                        expectQ.push_back(value);
                    end
                    "B": got = $fscanf(fd, "%d", budget);
                    default: abortRun($sformatf("unknown line kind %c in stimulus file", tag));
                endcase
            end
            $fclose(fd);
        end
        expectCount = expectQ.size();
    endtask

    task automatic streamProgram();
        int i;
        for (i = 0; i < loadAddrQ.size(); i++) begin
            loadValid <= 1'b1;
            load      <= {loadAddrQ[i], loadDataQ[i]};
            @(posedge clk);
            while (!loadReady) begin
                @(posedge clk);
            end
        end
        loadValid <= 1'b0;
    endtask

    initial begin
        rstN      = 1'b0;
        run       = 1'b0;
        loadValid = 1'b0;
        load      = '0;
        portReady = 1'b0;
        readStimulus();
        if (budget <= 0 || expectCount == 0 || loadAddrQ.size() == 0) begin
            abortRun("stimulus file lacks code, expected bytes or a cycle budget");
        end else begin
            repeat (3) @(posedge clk);
            rstN <= 1'b1;
            @(posedge clk);
            streamProgram();
            running <= 1'b1;
            wait (received == expectCount);
            // idle time to catch stray port writes
            repeat (40) @(posedge clk);
            $display("Test OK");
            $finish;
        end
    end

    // random back-pressure on port 2 and random pauses of the core
    always @(posedge clk) begin
        portReady <= 1'($random(seed));
        if (running) begin
            run <= ($random(seed) & 3) != 0;
        end
    end

    // valid and ready only move on rising edges, so the falling edge sees the transfer
    always @(negedge clk) begin
        if (rstN && portValid && portReady) begin
            if (received < expectCount) begin
                checkValue(portData, expectQ[received], received);
                received = received + 1;
            end else begin
                abortRun($sformatf("port 2 sent %02h after the last expected byte", portData));
            end
        end
    end

    initial begin
        wait (budget > 0);
        #(budget * 8);
        abortRun($sformatf("Timeout: port 2 output stalled, %0d of %0d bytes after %0d cycles",
                           received, expectCount, budget));
    end

endmodule

// File: bench/z8Stimulus.txt
# L <addr> <byte>: code byte to load, E <byte>: next port 2 value, B <cycles>: cycle budget
# addresses and bytes in hex, the budget in decimal
L 000C 5C  # ld r5,#35
L 000D 35
L 000E 6C  # ld r6,#0F
L 000F 0F
L 0010 7C  # ld r7,#80
L 0011 80
L 0012 8C  # ld r8,#00
L 0013 00
L 0014 2C  # ld r2,#A5
L 0015 A5
L 0016 02  # add r2,r5
L 0017 25
L 0018 22  # sub r2,r7
L 0019 27
L 001A 32  # sbc r2,r7, borrow out
L 001B 27
L 001C 12  # adc r2,r6, carry in
L 001D 26
L 001E 42  # or r2,r6
L 001F 26
L 0020 52  # and r2,r5
L 0021 25
L 0022 B2  # xor r2,r7
L 0023 27
L 0024 62  # tcm r2,r5
L 0025 25
L 0026 72  # tm r2,r6
L 0027 26
L 0028 A2  # cp r2,r7
L 0029 27
L 002A 02  # add r2,r8 shows r2 untouched
L 002B 28
L 002C 2E  # inc r2
L 002D A2  # cp r5,r6
L 002E 56
L 002F BB  # jr ugt,+2 taken
L 0030 02
L 0031 2C
L 0032 EE
L 0033 6B  # jr eq,+2 not taken
L 0034 02
L 0035 2C
L 0036 11
L 0037 ED  # jp ne,003C taken
L 0038 00
L 0039 3C
L 003A 2C
L 003B EE
L 003C 7D  # jp c,003A not taken
L 003D 00
L 003E 3A
L 003F 2C
L 0040 22
L 0041 9C  # ld r9,#03
L 0042 03
L 0043 2C  # loop body
L 0044 44
L 0045 9A  # djnz r9,loop
L 0046 FC
L 0047 DF  # scf
L 0048 2C
L 0049 00
L 004A 12  # adc r2,r8
L 004B 28
L 004C EF  # ccf
L 004D 2C
L 004E 00
L 004F 12
L 0050 28
L 0051 DF  # scf then rcf
L 0052 CF
L 0053 2C
L 0054 00
L 0055 12
L 0056 28
L 0057 8B  # jr always to itself
L 0058 FE
# ld and alu chain
E A5
E DA
E 5A
E DA
E EA
E EF
E 25
E A5
E A5
E A6
# branch markers
E 11
E 22
# djnz body
E 44
E 44
E 44
# carry ops
E 00
E 01
E 00
E 01
E 00
E 00
B 2000

// File: sources.f
hw/z8IsaPkg.sv
hw/z8BusPkg.sv
hw/codeMemory.sv
hw/alu.sv
hw/registerFile.sv
hw/instrSequencer.sv
hw/z8Soc.sv
bench/z8Soc_props.sv
bench/z8SocTb.sv

// File: Bender.yml
package:
  name: z8soc

sources:
  - hw/z8IsaPkg.sv
  - hw/z8BusPkg.sv
  - hw/codeMemory.sv
  - hw/alu.sv
  - hw/registerFile.sv
  - hw/instrSequencer.sv
  - hw/z8Soc.sv
  - target: simulation
    files:
      - bench/z8Soc_props.sv
      - bench/z8SocTb.sv
